// ==== flist.f ====
+incdir+include
src/fp_types_pkg.sv
src/fp_stage_if.sv
src/fp_add_align.sv
src/fp_stage_fifo.sv
src/fp_normalize.sv
src/fp_round_pack.sv
src/fp_add_top.sv
testbench/tb_clock_gen.sv
testbench/fp_add_tb.sv

// ==== Makefile ====
TOP       ?= fp_add_tb
LINT_TOP  ?= fp_add_top
LOG       ?= sim.log
SEED      ?= 1
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/fp_add_tb.sv ====
`timescale 1ns/1ns
`include "fp_config.svh"

module fp_add_tb;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int RAND_SEED = 32'h274b_7263;
    localparam int EXTRA = 38;
    localparam int NUM_RANDOM = 400;
    localparam int MAX_DIRECTED = 64;
    localparam int WATCHDOG_NS = (RESET_CYCLES + 20 * (MAX_DIRECTED + NUM_RANDOM)) * CLK_PERIOD;
    localparam fp_types_pkg::fp32_t SPECIAL_PICK [8] = '{
        32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
        32'h7fc0_0000, 32'h0001_2345, 32'h7f7f_ffff, 32'h0080_0000
    };

    logic clk, rst_n;
    logic op_valid, op_sub, result_hold;
    fp_types_pkg::fp32_t op_a, op_b, result;
    logic full, result_valid, overflow, invalid;

    // Expected responses in issue order
    fp_types_pkg::fp32_t exp_word_q[$];
    logic exp_ovf_q[$];
    logic exp_inv_q[$];
    string name_q[$];
    int issue_cycle_q[$];

    int cycle = 0;
    int last_latency = 0;
    logic hold_at_edge = 1'b0;
    logic saw_full = 1'b0;
    string cur_name;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fp_add_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op_sub       (op_sub),
        .op_a         (op_a),
        .op_b         (op_b),
        .result_hold  (result_hold),
        .full         (full),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow),
        .invalid      (invalid)
    );

    // Significands carry 38 extra bits and anything lower jams into bit 0
    function automatic void ref_fp_add(
        input  fp_types_pkg::fp32_t a,
        input  fp_types_pkg::fp32_t b,
        input  logic                sub,
        output fp_types_pkg::fp32_t word,
        output logic                ovf,
        output logic                inv
    );
        logic sa, sb, sl, nan_a, nan_b, inf_a, inf_b;
        logic [30:0] mag_a, mag_b;
        int ea, eb, el, es, e, diff, msb, drop;
        logic [63:0] ma, mb, ml, ms, ms_aln, sum, sig, rem, half;
        sa = a[31];
        sb = b[31] ^ sub;
        ea = a[30:23];
        eb = b[30:23];
        nan_a = (ea == 255) && (a[22:0] != 0);
        nan_b = (eb == 255) && (b[22:0] != 0);
        inf_a = (ea == 255) && (a[22:0] == 0);
        inf_b = (eb == 255) && (b[22:0] == 0);
        ovf = 1'b0;
        inv = 1'b0;
        if (nan_a || nan_b || (inf_a && inf_b && (sa != sb))) begin
            word = 32'h7fc0_0000;
            inv = 1'b1;
        end else if (inf_a) begin
            word = {sa, 8'hff, 23'h0};
        end else if (inf_b) begin
            word = {sb, 8'hff, 23'h0};
        end else begin
            // Subnormals count as zero
            mag_a = (ea == 0) ? 31'h0 : a[30:0];
            mag_b = (eb == 0) ? 31'h0 : b[30:0];
            ma = (ea == 0) ? 64'h0 : 64'({1'b1, a[22:0]}) << EXTRA;
            mb = (eb == 0) ? 64'h0 : 64'({1'b1, b[22:0]}) << EXTRA;
            if (mag_b > mag_a) begin
                sl = sb;
                el = eb;
                es = ea;
                ml = mb;
                ms = ma;
            end else begin
                sl = sa;
                el = ea;
                es = eb;
                ml = ma;
                ms = mb;
            end
            diff = el - es;
            if (diff > 62) begin
                ms_aln = (ms != 0) ? 64'h1 : 64'h0;
            end else begin
                ms_aln = ms >> diff;
                if ((ms & ((64'h1 << diff) - 1)) != 0) begin
                    ms_aln[0] = 1'b1;
                end
            end
            sum = (sa != sb) ? ml - ms_aln : ml + ms_aln;
            if (sum == 0) begin
                word = {sa & sb, 31'h0};
            end else begin
                msb = 63;
                while (!sum[msb]) begin
                    msb = msb - 1;
                end
                e = el + msb - (23 + EXTRA);
                drop = msb - 23;
                sig = sum >> drop;
                rem = sum & ((64'h1 << drop) - 1);
                half = 64'h1 << (drop - 1);
                if ((rem > half) || ((rem == half) && sig[0])) begin
                    sig = sig + 1;
                end
                if (sig[24]) begin
                    sig = sig >> 1;
                    e = e + 1;
                end
                if (el + msb - (23 + EXTRA) <= 0) begin
                    word = {sl, 31'h0};
                end else if (e >= 255) begin
                    word = {sl, 8'hff, 23'h0};
                    ovf = 1'b1;
                end else begin
                    word = {sl, e[7:0], sig[22:0]};
                end
            end
        end
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_result(input string name, input fp_types_pkg::fp32_t expected,
                                input fp_types_pkg::fp32_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive_op(input string name, input fp_types_pkg::fp32_t a,
                            input fp_types_pkg::fp32_t b, input logic sub);
        fp_types_pkg::fp32_t word;
        logic ovf, inv;
        ref_fp_add(a, b, sub, word, ovf, inv);
        op_valid = 1'b1;
        op_a = a;
        op_b = b;
        op_sub = sub;
        exp_word_q.push_back(word);
        exp_ovf_q.push_back(ovf);
        exp_inv_q.push_back(inv);
        name_q.push_back(name);
        issue_cycle_q.push_back(cycle);
    endtask

    task automatic issue_op(input string name, input fp_types_pkg::fp32_t a,
                            input fp_types_pkg::fp32_t b, input logic sub);
        drive_op(name, a, b, sub);
        step();
        op_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_word_q.size() != 0) begin
            step();
        end
    endtask

    task automatic run_directed();
        issue_op("equal expo sub", 32'h3fc0_0000, 32'h3f80_0000, 1'b1);
        issue_op("carry right shift", 32'h3f80_0000, 32'h3f80_0000, 1'b0);
        issue_op("carry odd", 32'h3fc0_0000, 32'h3fa0_0000, 1'b0);
        issue_op("long left shift", 32'h3f80_0001, 32'h3f80_0000, 1'b1);
        issue_op("left shift 24", 32'h3f80_0000, 32'h3f7f_ffff, 1'b1);
        issue_op("mixed signs", 32'hc120_0000, 32'h4040_0000, 1'b0);
        issue_op("far sticky add", 32'h4e80_0000, 32'h3f80_0001, 1'b0);
        issue_op("far sticky sub", 32'h3f80_0000, 32'h2f80_0001, 1'b1);
        issue_op("tie to even down", 32'h4b80_0000, 32'h3f80_0000, 1'b0);
        issue_op("tie to even up", 32'h4b80_0001, 32'h3f80_0000, 1'b0);
        issue_op("round up", 32'h3f80_0000, 32'h33c0_0000, 1'b0);
        issue_op("round down", 32'h3f80_0000, 32'h3300_0000, 1'b0);
        issue_op("round carry", 32'h3fff_ffff, 32'h3380_0000, 1'b0);
        issue_op("round carry int", 32'h4b7f_ffff, 32'h3f00_0000, 1'b0);
        issue_op("qnan input", 32'h7fc0_0000, 32'h3f80_0000, 1'b0);
        issue_op("snan input", 32'h3f80_0000, 32'h7f80_0001, 1'b0);
        issue_op("nan both", 32'hffc0_0001, 32'h7fa0_0000, 1'b1);
        issue_op("inf minus inf", 32'h7f80_0000, 32'h7f80_0000, 1'b1);
        issue_op("inf plus neg inf", 32'h7f80_0000, 32'hff80_0000, 1'b0);
        issue_op("inf plus finite", 32'h7f80_0000, 32'h3f80_0000, 1'b0);
        issue_op("finite minus inf", 32'h3f80_0000, 32'h7f80_0000, 1'b1);
        issue_op("neg inf plus finite", 32'hff80_0000, 32'h4200_0000, 1'b0);
        issue_op("inf plus inf", 32'h7f80_0000, 32'h7f80_0000, 1'b0);
        issue_op("exact cancel", 32'h3f80_0000, 32'h3f80_0000, 1'b1);
        issue_op("exact cancel neg", 32'hc040_0000, 32'h4040_0000, 1'b0);
        issue_op("neg zero sum", 32'h8000_0000, 32'h8000_0000, 1'b0);
        issue_op("neg zero minus zero", 32'h8000_0000, 32'h0000_0000, 1'b1);
        issue_op("zero plus neg zero", 32'h0000_0000, 32'h8000_0000, 1'b0);
        issue_op("subnormal inputs", 32'h0040_0000, 32'h0000_0001, 1'b0);
        issue_op("subnormal plus one", 32'h0040_0000, 32'h3f80_0000, 1'b0);
        issue_op("neg subnormal", 32'h8040_0000, 32'h8000_0000, 1'b0);
        issue_op("subnormal result", 32'h0080_0001, 32'h0080_0000, 1'b1);
        issue_op("subnormal result 2", 32'h00c0_0000, 32'h0080_0000, 1'b1);
        issue_op("overflow", 32'h7f7f_ffff, 32'h7f7f_ffff, 1'b0);
        issue_op("overflow neg", 32'hff7f_ffff, 32'hff00_0000, 1'b0);
        issue_op("round overflow", 32'h7f7f_ffff, 32'h7300_0000, 1'b0);
        issue_op("near max", 32'h7f7f_ffff, 32'h7280_0000, 1'b0);
    endtask

    task automatic run_latency();
        step();
        step();
        issue_op("latency", 32'h4049_0fdb, 32'h402d_f854, 1'b0);
        wait_drained();
        check_count("latency cycles", 3, last_latency);
        for (int i = 0; i < 8; i++) begin
            drive_op($sformatf("back to back %0d", i), 32'h4000_0000 + (i << 20),
                     32'h3fc0_0000 - (i << 19), i[0]);
            step();
        end
        op_valid = 1'b0;
        wait_drained();
    endtask

    function automatic fp_types_pkg::fp32_t random_operand();
        fp_types_pkg::fp32_t w;
        w = $urandom;
        // Mostly moderate exponents so the operands interact
        if ($urandom % 4 != 0) begin
            w[30:23] = 8'd100 + 8'($urandom % 56);
        end
        return w;
    endfunction

    function automatic fp_types_pkg::fp32_t random_partner(input fp_types_pkg::fp32_t a);
        fp_types_pkg::fp32_t w;
        w = $urandom;
        case ($urandom % 5)
            0: w[30:23] = a[30:23];
            1: w[30:23] = a[30:23] - 8'($urandom % 28);
            2: w = SPECIAL_PICK[$urandom % 8];
            3: w = a ^ 32'($urandom % 64);
            default: ;
        endcase
        return w;
    endfunction

    task automatic run_backpressure();
        fp_types_pkg::fp32_t a, b;
        int count;
        count = 0;
        while (count < NUM_RANDOM) begin
            if ($urandom % 8 == 0) begin
                result_hold = !result_hold;
            end
            op_valid = 1'b0;
            // Ops still in the align stage also need a FIFO slot
            if (!full && exp_word_q.size() < `FIFO_DEPTH && $urandom % 4 != 0) begin
                a = random_operand();
                b = random_partner(a);
                drive_op($sformatf("random %0d", count), a, b, $urandom % 2 == 1);
                count = count + 1;
            end
            step();
        end
        op_valid = 1'b0;
        result_hold = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        hold_at_edge <= result_hold;
        if (full) begin
            saw_full <= 1'b1;
        end
    end

    // Results are sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (rst_n && hold_at_edge) begin
            check_flag("no result under hold", 1'b0, result_valid);
        end
        if (rst_n && result_valid) begin
            if (exp_word_q.size() == 0) begin
                abort_run("result_valid seen with no operation pending");
            end else begin
                cur_name = name_q.pop_front();
                check_result(cur_name, exp_word_q.pop_front(), result);
                check_flag({cur_name, " overflow"}, exp_ovf_q.pop_front(), overflow);
                check_flag({cur_name, " invalid"}, exp_inv_q.pop_front(), invalid);
                last_latency = cycle - issue_cycle_q.pop_front();
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: results missing");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(RAND_SEED));
        op_valid = 1'b0;
        op_sub = 1'b0;
        op_a = '0;
        op_b = '0;
        result_hold = 1'b0;
        wait (rst_n === 1'b1);
        step();
        check_flag("reset result_valid", 1'b0, result_valid);
        check_flag("reset full", 1'b0, full);
        check_flag("reset overflow", 1'b0, overflow);
        check_flag("reset invalid", 1'b0, invalid);
        run_directed();
        wait_drained();
        run_latency();
        run_backpressure();
        wait_drained();
        repeat (8) step();
        check_flag("full seen under hold", 1'b1, saw_full);
        $display(">>> PASS");
        $finish;
    end
endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    // Release shortly after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end
endmodule

// ==== src/fp_add_top.sv ====
`timescale 1ns/1ns

module fp_add_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                op_valid,
    input  logic                op_sub,
    input  fp_types_pkg::fp32_t op_a,
    input  fp_types_pkg::fp32_t op_b,
    input  logic                result_hold,
    output logic                full,
    output logic                result_valid,
    output fp_types_pkg::fp32_t result,
    output logic                overflow,
    output logic                invalid
);
    // Align stage to buffer
    fp_stage_if stage_a ();

    // Buffer to round stage
    fp_stage_if stage_b ();

    fp_add_align u_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_valid (op_valid),
        .op_sub   (op_sub),
        .op_a     (op_a),
        .op_b     (op_b),
        .out_rec  (stage_a.source)
    );

    fp_stage_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_rec  (stage_a.sink),
        .out_rec (stage_b.source),
        .full    (full)
    );

    fp_round_pack u_round (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_rec       (stage_b.sink),
        .result_hold  (result_hold),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow),
        .invalid      (invalid)
    );
endmodule

// ==== src/fp_round_pack.sv ====
`timescale 1ns/1ns
`include "fp_config.svh"

module fp_round_pack (
    input  logic                clk,
    input  logic                rst_n,
    fp_stage_if.sink            in_rec,
    input  logic                result_hold,
    output logic                result_valid,
    output fp_types_pkg::fp32_t result,
    output logic                overflow,
    output logic                invalid
);
    localparam int EXPO_MAX = 2 * `EXPO_BIAS + 1;

    logic accept;
    logic sign_norm, expo_overflow_norm, hidden_bit_norm;
    fp_types_pkg::expo_t expo_norm;
    fp_types_pkg::frac_t frac_norm;
    fp_types_pkg::grs_t grs_norm;
    logic round_up;
    logic [`FRAC_WIDTH+1:0] sig_rnd;
    logic [`EXPO_WIDTH:0] expo_rnd;
    fp_types_pkg::fp32_t word;
    logic ovf, inv;

    assign in_rec.ready = !result_hold;
    assign accept = in_rec.valid && in_rec.ready;

    fp_normalize u_normalize (
        .sign               (in_rec.sign),
        .expo               (in_rec.expo),
        .expo_overflow      (in_rec.expo_overflow),
        .frac               (in_rec.frac),
        .left_shift_amt     (in_rec.left_shift_amt),
        .right_shift        (in_rec.right_shift),
        .right_shift_amt    (in_rec.right_shift_amt),
        .hidden_bit         (in_rec.hidden_bit),
        .frac_safe_bit      (in_rec.frac_safe_bit),
        .frac_carry_bit     (in_rec.frac_carry_bit),
        .grs_in             (in_rec.grs),
        .sign_norm          (sign_norm),
        .expo_norm          (expo_norm),
        .expo_overflow_norm (expo_overflow_norm),
        .frac_norm          (frac_norm),
        .hidden_bit_norm    (hidden_bit_norm),
        .grs_norm           (grs_norm)
    );

    // Nearest even; an all-ones significand carries into the exponent
    assign round_up = grs_norm[2] & (grs_norm[1] | grs_norm[0] | frac_norm[0]);
    assign sig_rnd = {1'b0, hidden_bit_norm, frac_norm} + (`FRAC_WIDTH + 2)'(round_up);
    assign expo_rnd = {expo_overflow_norm, expo_norm} + (`EXPO_WIDTH + 1)'(sig_rnd[`FRAC_WIDTH+1]);

    always_comb begin
        ovf = 1'b0;
        inv = 1'b0;
        word = {sign_norm, expo_rnd[`EXPO_WIDTH-1:0], sig_rnd[`FRAC_WIDTH-1:0]};
        case (in_rec.special)
            fp_types_pkg::SPECIAL_NAN: begin
                word = fp_types_pkg::CANONICAL_NAN;
                inv = 1'b1;
            end
            fp_types_pkg::SPECIAL_INF: begin
                word = {in_rec.special_sign, {`EXPO_WIDTH{1'b1}}, {`FRAC_WIDTH{1'b0}}};
            end
            fp_types_pkg::SPECIAL_ZERO: begin
                word = {in_rec.special_sign, {(`EXPO_WIDTH + `FRAC_WIDTH){1'b0}}};
            end
            default: begin
                // Subnormal result before rounding flushes to zero
                if ({expo_overflow_norm, expo_norm} == '0) begin
                    word = {sign_norm, {(`EXPO_WIDTH + `FRAC_WIDTH){1'b0}}};
                end else if (expo_rnd >= EXPO_MAX) begin
                    word = {sign_norm, {`EXPO_WIDTH{1'b1}}, {`FRAC_WIDTH{1'b0}}};
                    ovf = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            overflow <= 1'b0;
            invalid <= 1'b0;
        end else begin
            result_valid <= accept;
            if (accept) begin
                overflow <= ovf;
                invalid <= inv;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result <= word;
        end
    end
endmodule

// ==== src/fp_normalize.sv ====
`timescale 1ns/1ns
`include "fp_config.svh"

module fp_normalize (
    input  logic                     sign,
    input  fp_types_pkg::expo_t      expo,
    input  logic                     expo_overflow,
    input  fp_types_pkg::frac_t      frac,
    input  fp_types_pkg::shift_amt_t left_shift_amt,
    input  logic                     right_shift,
    input  fp_types_pkg::expo_t      right_shift_amt,
    input  logic                     hidden_bit,
    input  logic                     frac_safe_bit,
    input  logic                     frac_carry_bit,
    input  fp_types_pkg::grs_t       grs_in,
    output logic                     sign_norm,
    output fp_types_pkg::expo_t      expo_norm,
    output logic                     expo_overflow_norm,
    output fp_types_pkg::frac_t      frac_norm,
    output logic                     hidden_bit_norm,
    output fp_types_pkg::grs_t       grs_norm
);
    // Safe bit, carry bit, hidden bit, fraction, guard/round/sticky
    localparam int VEC_W = `FRAC_WIDTH + 6;
    localparam int XEXP_W = `EXPO_WIDTH + 1;

    logic [VEC_W-1:0] sig_vec, vec_right, vec_left, lost_mask;
    logic [XEXP_W-1:0] expo_ext, expo_right, expo_left_diff, expo_left;
    logic [1:0] right_amt;
    logic right_sticky;
    logic left_borrow;
    fp_types_pkg::shift_amt_t left_amt;

    assign sign_norm = sign;
    assign sig_vec = {frac_safe_bit, frac_carry_bit, hidden_bit, frac, grs_in};
    assign expo_ext = {expo_overflow, expo};

    // Right path, never more than two places
    assign right_amt = right_shift_amt[1:0];
    assign expo_right = expo_ext + XEXP_W'(right_amt);

    // Bits shifted out must stay visible in sticky
    assign lost_mask = ~({VEC_W{1'b1}} << right_amt);
    assign right_sticky = |(sig_vec & lost_mask);

    always_comb begin
        vec_right = sig_vec >> right_amt;
        vec_right[0] = vec_right[0] | right_sticky;
    end

    // Left path, clamped so the exponent stops at zero
    assign {left_borrow, expo_left_diff} = {1'b0, expo_ext} - (XEXP_W + 1)'(left_shift_amt);
    assign left_amt = left_borrow ? fp_types_pkg::shift_amt_t'(expo_ext) : left_shift_amt;
    assign vec_left = sig_vec << left_amt;
    assign expo_left = left_borrow ? '0 : expo_left_diff;

    always_comb begin
        if (right_shift) begin
            {expo_overflow_norm, expo_norm} = expo_right;
            {hidden_bit_norm, frac_norm, grs_norm} = vec_right[`FRAC_WIDTH+3:0];
        end else begin
            {expo_overflow_norm, expo_norm} = expo_left;
            {hidden_bit_norm, frac_norm, grs_norm} = vec_left[`FRAC_WIDTH+3:0];
        end
    end
endmodule

// ==== src/fp_stage_fifo.sv ====
`timescale 1ns/1ns
`include "fp_config.svh"

module fp_stage_fifo (
    input  logic       clk,
    input  logic       rst_n,
    fp_stage_if.sink   in_rec,
    fp_stage_if.source out_rec,
    output logic       full
);
    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    // Every record field except valid
    localparam int REC_W = 2 * $bits(fp_types_pkg::expo_t) + $bits(fp_types_pkg::frac_t)
                         + $bits(fp_types_pkg::grs_t) + $bits(fp_types_pkg::shift_amt_t)
                         + $bits(fp_types_pkg::special_t) + 7;

    logic [REC_W-1:0] mem [DEPTH];
    logic [REC_W-1:0] wr_data, rd_data;
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0] count;
    logic push, pop;

    assign wr_data = {in_rec.sign, in_rec.expo, in_rec.expo_overflow, in_rec.frac,
                      in_rec.hidden_bit, in_rec.frac_safe_bit, in_rec.frac_carry_bit,
                      in_rec.grs, in_rec.left_shift_amt, in_rec.right_shift,
                      in_rec.right_shift_amt, in_rec.special, in_rec.special_sign};

    // Oldest entry is always on the output
    assign rd_data = mem[rd_ptr];
    assign {out_rec.sign, out_rec.expo, out_rec.expo_overflow, out_rec.frac,
            out_rec.hidden_bit, out_rec.frac_safe_bit, out_rec.frac_carry_bit,
            out_rec.grs, out_rec.left_shift_amt, out_rec.right_shift,
            out_rec.right_shift_amt, out_rec.special, out_rec.special_sign} = rd_data;

    assign full = (count == (PTR_W + 1)'(DEPTH));
    assign out_rec.valid = (count != '0);
    assign in_rec.ready = !full;

    // A write into a full buffer is lost
    assign push = in_rec.valid && !full;
    assign pop = out_rec.valid && out_rec.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end
endmodule

// ==== src/fp_add_align.sv ====
`timescale 1ns/1ns
`include "fp_config.svh"

module fp_add_align (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                op_valid,
    input  logic                op_sub,
    input  fp_types_pkg::fp32_t op_a,
    input  fp_types_pkg::fp32_t op_b,
    fp_stage_if.source          out_rec
);
    localparam int SIGN_POS = `EXPO_WIDTH + `FRAC_WIDTH;
    localparam int SIG_W = `FRAC_WIDTH + 1;
    localparam int ALN_W = SIG_W + 3;
    localparam int SUM_W = ALN_W + 1;
    localparam fp_types_pkg::expo_t EXPO_MAX = fp_types_pkg::expo_t'(2 * `EXPO_BIAS + 1);

    logic sign_a, sign_b, sign_l, eff_sub;
    fp_types_pkg::expo_t expo_a, expo_b, expo_l, expo_s, expo_diff;
    fp_types_pkg::frac_t frac_a, frac_b;
    logic zero_a, zero_b, nan_a, nan_b, inf_a, inf_b;
    logic [SIG_W-1:0] sig_a, sig_b, sig_l, sig_s;
    logic [ALN_W-1:0] sig_s_ext, sig_s_aln, sticky_mask;
    logic sticky;
    logic [SUM_W-1:0] sum;
    fp_types_pkg::shift_amt_t lzc;
    fp_types_pkg::special_t special;
    logic special_sign;

    // Unpack, b takes the inverted sign for a subtraction
    assign sign_a = op_a[SIGN_POS];
    assign sign_b = op_b[SIGN_POS] ^ op_sub;
    assign expo_a = op_a[`FRAC_WIDTH +: `EXPO_WIDTH];
    assign expo_b = op_b[`FRAC_WIDTH +: `EXPO_WIDTH];

    // Subnormal inputs flush to zero
    assign zero_a = (expo_a == '0);
    assign zero_b = (expo_b == '0);
    assign frac_a = zero_a ? '0 : op_a[`FRAC_WIDTH-1:0];
    assign frac_b = zero_b ? '0 : op_b[`FRAC_WIDTH-1:0];
    assign sig_a = {!zero_a, frac_a};
    assign sig_b = {!zero_b, frac_b};

    assign nan_a = (expo_a == EXPO_MAX) && (frac_a != '0);
    assign nan_b = (expo_b == EXPO_MAX) && (frac_b != '0);
    assign inf_a = (expo_a == EXPO_MAX) && (frac_a == '0);
    assign inf_b = (expo_b == EXPO_MAX) && (frac_b == '0);
    assign eff_sub = sign_a ^ sign_b;

    // Larger magnitude goes first
    always_comb begin
        if ({expo_b, frac_b} > {expo_a, frac_a}) begin
            sign_l = sign_b;
            expo_l = expo_b;
            expo_s = expo_a;
            sig_l = sig_b;
            sig_s = sig_a;
        end else begin
            sign_l = sign_a;
            expo_l = expo_a;
            expo_s = expo_b;
            sig_l = sig_a;
            sig_s = sig_b;
        end
    end

    // Align the smaller significand, everything past the round bit folds into sticky
    assign expo_diff = expo_l - expo_s;
    assign sig_s_ext = {sig_s, 3'b000};

    always_comb begin
        sticky_mask = '0;
        if (expo_diff >= ALN_W) begin
            sig_s_aln = '0;
            sticky = |sig_s;
        end else begin
            sticky_mask = ~({ALN_W{1'b1}} << expo_diff);
            sticky = |(sig_s_ext & sticky_mask);
            sig_s_aln = sig_s_ext >> expo_diff;
        end
        sig_s_aln[0] = sig_s_aln[0] | sticky;
    end

    // Carry lands in the top bit of the sum
    assign sum = eff_sub ? {1'b0, sig_l, 3'b000} - {1'b0, sig_s_aln}
                         : {1'b0, sig_l, 3'b000} + {1'b0, sig_s_aln};

    // Leading zeros above the hidden bit position, highest set bit wins
    always_comb begin
        lzc = '0;
        for (int i = 0; i < ALN_W; i++) begin
            if (sum[i]) begin
                lzc = fp_types_pkg::shift_amt_t'(ALN_W - 1 - i);
            end
        end
    end

    always_comb begin
        special = fp_types_pkg::SPECIAL_NORMAL;
        special_sign = sign_l;
        if (nan_a || nan_b || (inf_a && inf_b && eff_sub)) begin
            special = fp_types_pkg::SPECIAL_NAN;
        end else if (inf_a) begin
            special = fp_types_pkg::SPECIAL_INF;
            special_sign = sign_a;
        end else if (inf_b) begin
            special = fp_types_pkg::SPECIAL_INF;
            special_sign = sign_b;
        end else if (sum == '0) begin
            // Negative only for (-0) + (-0)
            special = fp_types_pkg::SPECIAL_ZERO;
            special_sign = sign_a & sign_b;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_rec.valid <= 1'b0;
        end else begin
            out_rec.valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            out_rec.sign <= sign_l;
            out_rec.expo <= expo_l;
            out_rec.expo_overflow <= 1'b0;
            out_rec.frac <= sum[ALN_W-2:3];
            out_rec.hidden_bit <= sum[ALN_W-1];
            out_rec.frac_safe_bit <= 1'b0;
            out_rec.frac_carry_bit <= sum[SUM_W-1];
            out_rec.grs <= sum[2:0];
            out_rec.right_shift <= sum[SUM_W-1];
            out_rec.right_shift_amt <= fp_types_pkg::expo_t'(sum[SUM_W-1]);
            out_rec.left_shift_amt <= sum[SUM_W-1] ? '0 : lzc;
            out_rec.special <= special;
            out_rec.special_sign <= special_sign;
        end
    end
endmodule

// ==== src/fp_stage_if.sv ====
`timescale 1ns/1ns

interface fp_stage_if;
    logic                     valid;
    logic                     sign;
    fp_types_pkg::expo_t      expo;
    logic                     expo_overflow;
    fp_types_pkg::frac_t      frac;
    logic                     hidden_bit;
    logic                     frac_safe_bit;
    logic                     frac_carry_bit;
    fp_types_pkg::grs_t       grs;
    fp_types_pkg::shift_amt_t left_shift_amt;
    logic                     right_shift;
    fp_types_pkg::expo_t      right_shift_amt;
    fp_types_pkg::special_t   special;
    logic                     special_sign;
    // Level from the receiving side, not a handshake
    logic                     ready;

    modport source (
        output valid, sign, expo, expo_overflow, frac, hidden_bit, frac_safe_bit,
               frac_carry_bit, grs, left_shift_amt, right_shift, right_shift_amt,
               special, special_sign,
        input  ready
    );

    modport sink (
        input  valid, sign, expo, expo_overflow, frac, hidden_bit, frac_safe_bit,
               frac_carry_bit, grs, left_shift_amt, right_shift, right_shift_amt,
               special, special_sign,
        output ready
    );
endinterface

// ==== src/fp_types_pkg.sv ====
package fp_types_pkg;

    `include "fp_config.svh"

    // Packed IEEE word
    typedef logic [`EXPO_WIDTH+`FRAC_WIDTH:0] fp32_t;

    // Biased exponent and stored fraction
    typedef logic [`EXPO_WIDTH-1:0] expo_t;
    typedef logic [`FRAC_WIDTH-1:0] frac_t;

    // Guard, round and sticky, guard in the top bit
    typedef logic [2:0] grs_t;

    // Left shift taken from the leading zero count
    typedef logic [4:0] shift_amt_t;

    // Special result code carried with each record
    typedef logic [1:0] special_t;

    localparam special_t SPECIAL_NORMAL = 2'd0;
    localparam special_t SPECIAL_ZERO   = 2'd1;
    localparam special_t SPECIAL_INF    = 2'd2;
    localparam special_t SPECIAL_NAN    = 2'd3;

    localparam fp32_t CANONICAL_NAN = 32'h7fc0_0000;

endpackage

// ==== include/fp_config.svh ====
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// IEEE single precision format
`define EXPO_WIDTH 8
`define FRAC_WIDTH 23
`define EXPO_BIAS 127

// Records buffered between the align and round stages (power of two)
`define FIFO_DEPTH 4

`endif
